// ==== include/noc_bridge_defs.svh ====
`ifndef NOC_BRIDGE_DEFS_SVH
`define NOC_BRIDGE_DEFS_SVH

// AXI side
`define NB_ADDR_WIDTH 16
`define NB_DATA_WIDTH 32
`define NB_STRB_WIDTH 4
`define NB_ID_WIDTH 4

// Stream side, one flit per beat
`define NB_FLIT_WIDTH 40

`define NB_MESH_X 4
`define NB_MESH_Y 4
`define NB_COORD_X_WIDTH 2
`define NB_COORD_Y_WIDTH 2

// Flit kinds carried on TID
`define NB_KIND_WIDTH 3
`define NB_KIND_ROUTING_HEADER 3'd0
`define NB_KIND_AW_SUBHEADER 3'd1
`define NB_KIND_AR_SUBHEADER 3'd2
`define NB_KIND_W_DATA 3'd3
`define NB_KIND_B_SUBHEADER 3'd4
`define NB_KIND_R_DATA 3'd5

`endif

// ==== logic/noc_bridge_pkg.sv ====
`include "noc_bridge_defs.svh"

package noc_bridge_pkg;

    localparam int HDR_RSVD_WIDTH =
        `NB_FLIT_WIDTH - 8 - 2 * (`NB_COORD_X_WIDTH + `NB_COORD_Y_WIDTH);
    localparam int SUB_RSVD_WIDTH = `NB_FLIT_WIDTH - (`NB_ID_WIDTH + `NB_ADDR_WIDTH + 8 + 3 + 2);

    typedef enum logic [`NB_KIND_WIDTH-1:0] {
        ROUTING_HEADER = `NB_KIND_ROUTING_HEADER,
        AW_SUBHEADER   = `NB_KIND_AW_SUBHEADER,
        AR_SUBHEADER   = `NB_KIND_AR_SUBHEADER,
        W_DATA         = `NB_KIND_W_DATA,
        B_SUBHEADER    = `NB_KIND_B_SUBHEADER,
        R_DATA         = `NB_KIND_R_DATA
    } flit_kind_e;

    typedef struct packed {
        logic [HDR_RSVD_WIDTH-1:0]       reserved;
        logic [7:0]                      packet_count;
        logic [`NB_COORD_X_WIDTH-1:0]    source_x;
        logic [`NB_COORD_Y_WIDTH-1:0]    source_y;
        logic [`NB_COORD_X_WIDTH-1:0]    dest_x;
        logic [`NB_COORD_Y_WIDTH-1:0]    dest_y;
    } routing_header_t;

    // Same layout for AW and AR
    typedef struct packed {
        logic [SUB_RSVD_WIDTH-1:0] reserved;
        logic [`NB_ID_WIDTH-1:0]   id;
        logic [`NB_ADDR_WIDTH-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } addr_subheader_t;

    typedef struct packed {
        logic [`NB_FLIT_WIDTH-`NB_DATA_WIDTH-1:0] reserved;
        logic [`NB_DATA_WIDTH-1:0]                data;
    } w_flit_t;

    typedef struct packed {
        logic [`NB_FLIT_WIDTH-`NB_ID_WIDTH-1:0] reserved;
        logic [`NB_ID_WIDTH-1:0]                id;
    } b_flit_t;

    typedef struct packed {
        logic [`NB_FLIT_WIDTH-`NB_ID_WIDTH-`NB_DATA_WIDTH-1:0] reserved;
        logic [`NB_ID_WIDTH-1:0]                               id;
        logic [`NB_DATA_WIDTH-1:0]                             data;
    } r_flit_t;

    typedef struct packed {
        logic [`NB_ID_WIDTH-1:0]   id;
        logic [`NB_ADDR_WIDTH-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } axi_addr_t;

    typedef struct packed {
        logic [`NB_DATA_WIDTH-1:0] data;
        logic [`NB_STRB_WIDTH-1:0] strb;
        logic                      last;
    } axi_w_t;

    typedef struct packed {
        logic [`NB_ID_WIDTH-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [`NB_ID_WIDTH-1:0]   id;
        logic [`NB_DATA_WIDTH-1:0] data;
        logic                      last;
    } axi_r_t;

    typedef struct packed {
        flit_kind_e                tid;
        logic [`NB_FLIT_WIDTH-1:0] tdata;
        logic [`NB_STRB_WIDTH-1:0] tstrb;
        logic                      tlast;
    } axis_flit_t;

    typedef enum logic [1:0] {SEND_HEADER, SEND_AW, SEND_AR, SEND_W} req_state_e;

    typedef enum logic {REQ_AW, REQ_AR} req_kind_e;

endpackage

// ==== logic/req_arbiter.sv ====
`timescale 1ns/1ps

module req_arbiter (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic                      aw_valid_i,
    input  logic                      ar_valid_i,
    input  logic                      packet_done_i,
    output logic                      grant_valid_o,
    output noc_bridge_pkg::req_kind_e grant_kind_o
);

    logic                      locked_q;
    logic                      ar_first_q;  // AR wins a tie when set
    noc_bridge_pkg::req_kind_e grant_q;
    noc_bridge_pkg::req_kind_e pick;

    always_comb begin
        if (aw_valid_i && ar_valid_i) begin
            pick = ar_first_q ? noc_bridge_pkg::REQ_AR : noc_bridge_pkg::REQ_AW;
        end
        else if (ar_valid_i) begin
            pick = noc_bridge_pkg::REQ_AR;
        end
        else begin
            pick = noc_bridge_pkg::REQ_AW;
        end
    end

    // Unlocked grant is combinational so the header goes out in the request cycle
    assign grant_valid_o = locked_q || aw_valid_i || ar_valid_i;
    assign grant_kind_o  = locked_q ? grant_q : pick;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            locked_q   <= 1'b0;
            ar_first_q <= 1'b0;
            grant_q    <= noc_bridge_pkg::REQ_AW;
        end
        else if (locked_q) begin
            if (packet_done_i) begin
                locked_q   <= 1'b0;
                ar_first_q <= (grant_q == noc_bridge_pkg::REQ_AW);  // Other kind goes next
            end
        end
        else if (aw_valid_i || ar_valid_i) begin
            locked_q <= 1'b1;
            grant_q  <= pick;
        end
    end

    a_done_when_locked: assert property (@(posedge ACLK) disable iff (!ARESETn)
        packet_done_i |-> locked_q);

    // Covers the cycle where the combinational grant is captured into the lock
    a_grant_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
        grant_valid_o && !packet_done_i |=> grant_valid_o && $stable(grant_kind_o));

endmodule

// ==== logic/req_packetizer.sv ====
`timescale 1ns/1ps
`include "noc_bridge_defs.svh"

module req_packetizer #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                       ACLK,
    input  logic                       ARESETn,
    input  logic                       grant_valid_i,
    input  noc_bridge_pkg::req_kind_e  grant_kind_i,
    input  noc_bridge_pkg::axi_addr_t  aw_i,
    input  noc_bridge_pkg::axi_addr_t  ar_i,
    input  logic                       aw_valid_i,
    input  logic                       ar_valid_i,
    input  noc_bridge_pkg::axi_w_t     w_i,
    input  logic                       w_valid_i,
    input  logic                       req_ready_i,
    output logic                       aw_ready_o,
    output logic                       ar_ready_o,
    output logic                       w_ready_o,
    output noc_bridge_pkg::axis_flit_t req_flit_o,
    output logic                       req_valid_o,
    output logic                       packet_done_o
);

    noc_bridge_pkg::req_state_e      state_q, state_d;
    noc_bridge_pkg::axi_addr_t       granted;
    noc_bridge_pkg::routing_header_t header;
    noc_bridge_pkg::w_flit_t         w_flit;
    logic [`NB_ID_WIDTH-1:0]         dest_idx;

    function automatic noc_bridge_pkg::addr_subheader_t pack_addr(
        input noc_bridge_pkg::axi_addr_t a
    );
        noc_bridge_pkg::addr_subheader_t s;
        s          = '0;
        s.id       = a.id;
        s.addr     = a.addr;
        s.len      = a.len;
        s.size     = a.size;
        s.burst    = a.burst;
        return s;
    endfunction

    assign granted  = (grant_kind_i == noc_bridge_pkg::REQ_AW) ? aw_i : ar_i;
    assign dest_idx = granted.id - 1'b1;  // Node IDs count from 1, row by row

    always_comb begin
        header              = '0;
        header.packet_count = (grant_kind_i == noc_bridge_pkg::REQ_AW) ? aw_i.len + 8'd2 : 8'd1;
        header.source_x     = `NB_COORD_X_WIDTH'(ROUTER_X);
        header.source_y     = `NB_COORD_Y_WIDTH'(ROUTER_Y);
        header.dest_x       = `NB_COORD_X_WIDTH'(dest_idx % `NB_MESH_X);
        header.dest_y       = `NB_COORD_Y_WIDTH'((dest_idx / `NB_MESH_X) % `NB_MESH_Y);
    end

    always_comb begin
        w_flit      = '0;
        w_flit.data = w_i.data;
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= noc_bridge_pkg::SEND_HEADER;
        end
        else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d          = state_q;
        req_flit_o       = '0;
        req_flit_o.tstrb = '1;
        req_valid_o      = 1'b0;
        aw_ready_o       = 1'b0;
        ar_ready_o       = 1'b0;
        w_ready_o        = 1'b0;
        packet_done_o    = 1'b0;

        case (state_q)
            noc_bridge_pkg::SEND_HEADER: begin
                req_flit_o.tid   = noc_bridge_pkg::ROUTING_HEADER;
                req_flit_o.tdata = header;
                req_valid_o      = grant_valid_i;
                if (grant_valid_i && req_ready_i) begin
                    state_d = (grant_kind_i == noc_bridge_pkg::REQ_AW) ?
                              noc_bridge_pkg::SEND_AW : noc_bridge_pkg::SEND_AR;
                end
            end
            noc_bridge_pkg::SEND_AW: begin
                req_flit_o.tid   = noc_bridge_pkg::AW_SUBHEADER;
                req_flit_o.tdata = pack_addr(aw_i);
                req_valid_o      = aw_valid_i;
                aw_ready_o       = req_ready_i;
                if (aw_valid_i && req_ready_i) begin
                    state_d = noc_bridge_pkg::SEND_W;
                end
            end
            noc_bridge_pkg::SEND_W: begin
                req_flit_o.tid   = noc_bridge_pkg::W_DATA;
                req_flit_o.tdata = w_flit;
                req_flit_o.tstrb = w_i.strb;
                req_flit_o.tlast = w_i.last;
                req_valid_o      = w_valid_i;
                w_ready_o        = req_ready_i;
                if (w_valid_i && req_ready_i && w_i.last) begin
                    packet_done_o = 1'b1;
                    state_d       = noc_bridge_pkg::SEND_HEADER;
                end
            end
            noc_bridge_pkg::SEND_AR: begin
                req_flit_o.tid   = noc_bridge_pkg::AR_SUBHEADER;
                req_flit_o.tdata = pack_addr(ar_i);
                req_flit_o.tlast = 1'b1;  // A read request is header plus this flit
                req_valid_o      = ar_valid_i;
                ar_ready_o       = req_ready_i;
                if (ar_valid_i && req_ready_i) begin
                    packet_done_o = 1'b1;
                    state_d       = noc_bridge_pkg::SEND_HEADER;
                end
            end
            default: begin
                state_d = noc_bridge_pkg::SEND_HEADER;
            end
        endcase
    end

    // Relies on the arbiter lock and on the master holding its payload
    a_flit_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        req_valid_o && !req_ready_i |=> $stable(req_flit_o));

endmodule

// ==== logic/resp_depacketizer.sv ====
`timescale 1ns/1ps

module resp_depacketizer (
    input  noc_bridge_pkg::axis_flit_t resp_flit_i,
    input  logic                       resp_valid_i,
    input  logic                       b_ready_i,
    input  logic                       r_ready_i,
    output logic                       resp_ready_o,
    output noc_bridge_pkg::axi_b_t     b_o,
    output logic                       b_valid_o,
    output noc_bridge_pkg::axi_r_t     r_o,
    output logic                       r_valid_o
);

    noc_bridge_pkg::b_flit_t b_flit;
    noc_bridge_pkg::r_flit_t r_flit;

    assign b_flit = resp_flit_i.tdata;
    assign r_flit = resp_flit_i.tdata;

    always_comb begin
        resp_ready_o = 1'b1;  // Headers and unknown kinds drain at once
        b_o          = '0;
        b_valid_o    = 1'b0;
        r_o          = '0;
        r_valid_o    = 1'b0;

        if (resp_valid_i) begin
            case (resp_flit_i.tid)
                noc_bridge_pkg::B_SUBHEADER: begin
                    resp_ready_o = b_ready_i;
                    b_valid_o    = 1'b1;
                    b_o.id       = b_flit.id;
                end
                noc_bridge_pkg::R_DATA: begin
                    resp_ready_o = r_ready_i;
                    r_valid_o    = 1'b1;
                    r_o.id       = r_flit.id;
                    r_o.data     = r_flit.data;
                    r_o.last     = resp_flit_i.tlast;  // Burst end rides on TLAST
                end
                default: begin
                    resp_ready_o = 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== logic/noc_initiator_bridge.sv ====
`timescale 1ns/1ps

module noc_initiator_bridge #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                       ACLK,
    input  logic                       ARESETn,
    input  noc_bridge_pkg::axi_addr_t  aw_i,
    input  logic                       aw_valid_i,
    output logic                       aw_ready_o,
    input  noc_bridge_pkg::axi_addr_t  ar_i,
    input  logic                       ar_valid_i,
    output logic                       ar_ready_o,
    input  noc_bridge_pkg::axi_w_t     w_i,
    input  logic                       w_valid_i,
    output logic                       w_ready_o,
    output noc_bridge_pkg::axi_b_t     b_o,
    output logic                       b_valid_o,
    input  logic                       b_ready_i,
    output noc_bridge_pkg::axi_r_t     r_o,
    output logic                       r_valid_o,
    input  logic                       r_ready_i,
    output noc_bridge_pkg::axis_flit_t req_flit_o,
    output logic                       req_valid_o,
    input  logic                       req_ready_i,
    input  noc_bridge_pkg::axis_flit_t resp_flit_i,
    input  logic                       resp_valid_i,
    output logic                       resp_ready_o
);

    logic                      grant_valid;
    noc_bridge_pkg::req_kind_e grant_kind;
    logic                      packet_done;

    req_arbiter u_req_arbiter (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .aw_valid_i    (aw_valid_i),
        .ar_valid_i    (ar_valid_i),
        .packet_done_i (packet_done),
        .grant_valid_o (grant_valid),
        .grant_kind_o  (grant_kind)
    );

    req_packetizer #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) u_req_packetizer (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .grant_valid_i (grant_valid),
        .grant_kind_i  (grant_kind),
        .aw_i          (aw_i),
        .ar_i          (ar_i),
        .aw_valid_i    (aw_valid_i),
        .ar_valid_i    (ar_valid_i),
        .w_i           (w_i),
        .w_valid_i     (w_valid_i),
        .req_ready_i   (req_ready_i),
        .aw_ready_o    (aw_ready_o),
        .ar_ready_o    (ar_ready_o),
        .w_ready_o     (w_ready_o),
        .req_flit_o    (req_flit_o),
        .req_valid_o   (req_valid_o),
        .packet_done_o (packet_done)
    );

    resp_depacketizer u_resp_depacketizer (
        .resp_flit_i  (resp_flit_i),
        .resp_valid_i (resp_valid_i),
        .b_ready_i    (b_ready_i),
        .r_ready_i    (r_ready_i),
        .resp_ready_o (resp_ready_o),
        .b_o          (b_o),
        .b_valid_o    (b_valid_o),
        .r_o          (r_o),
        .r_valid_o    (r_valid_o)
    );

    // One response flit can only feed one AXI channel
    a_b_r_exclusive: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(b_valid_o && r_valid_o));

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic aclk_o,
    output logic aresetn_o
);

    initial begin
        aclk_o = 1'b0;
        forever #(PERIOD_NS / 2) aclk_o = ~aclk_o;
    end

    initial begin
        aresetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk_o);
        @(negedge aclk_o);  // Release away from the rising edge
        aresetn_o = 1'b1;
    end

endmodule

// ==== dv/tb_noc_initiator_bridge.sv ====
`timescale 1ns/1ps
`include "noc_bridge_defs.svh"

module tb_noc_initiator_bridge;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int SAMPLE_DELAY = CLK_PERIOD / 4;  // Outputs are read a quarter period before the edge
    localparam int ROUTER_X     = 1;
    localparam int ROUTER_Y     = 2;
    localparam int NUM_ROWS     = 6;
    localparam int MAX_LEN      = 7;
    localparam int TIMEOUT_NS   = (NUM_ROWS * (MAX_LEN + 4) * 8 + RESET_CYCLES + 2) * CLK_PERIOD;

    localparam logic [1:0] KIND_WRITE = 2'd0;
    localparam logic [1:0] KIND_READ  = 2'd1;
    localparam logic [1:0] KIND_BOTH  = 2'd2;

    typedef struct packed {
        logic [1:0]                kind;
        noc_bridge_pkg::axi_addr_t aw;
        noc_bridge_pkg::axi_addr_t ar;
        logic [31:0]               wdata;
        logic [3:0]                wstrb;
        logic [31:0]               rdata;
        logic [1:0]                resp_count;
        logic [8:0]                resp_kinds;  // TID codes, first flit in the low bits
    } row_t;

    logic                       ACLK;
    logic                       ARESETn;
    noc_bridge_pkg::axi_addr_t  aw_i;
    logic                       aw_valid_i;
    logic                       aw_ready_o;
    noc_bridge_pkg::axi_addr_t  ar_i;
    logic                       ar_valid_i;
    logic                       ar_ready_o;
    noc_bridge_pkg::axi_w_t     w_i;
    logic                       w_valid_i;
    logic                       w_ready_o;
    noc_bridge_pkg::axi_b_t     b_o;
    logic                       b_valid_o;
    logic                       b_ready_i;
    noc_bridge_pkg::axi_r_t     r_o;
    logic                       r_valid_o;
    logic                       r_ready_i;
    noc_bridge_pkg::axis_flit_t req_flit_o;
    logic                       req_valid_o;
    logic                       req_ready_i;
    noc_bridge_pkg::axis_flit_t resp_flit_i;
    logic                       resp_valid_i;
    logic                       resp_ready_o;

    row_t                       rows [NUM_ROWS];
    noc_bridge_pkg::axis_flit_t exp_q [$];
    noc_bridge_pkg::axis_flit_t got_q [$];
    int                         errors;
    int                         checks;
    logic                       next_is_ar;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .aclk_o    (ACLK),
        .aresetn_o (ARESETn)
    );

    noc_initiator_bridge #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) u_dut (.*);

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic noc_bridge_pkg::axi_addr_t make_addr(input logic [3:0] id,
            input logic [15:0] addr, input logic [7:0] len, input logic [2:0] size,
            input logic [1:0] burst);
        noc_bridge_pkg::axi_addr_t a;
        a.id    = id;
        a.addr  = addr;
        a.len   = len;
        a.size  = size;
        a.burst = burst;
        return a;
    endfunction

    function automatic noc_bridge_pkg::axi_w_t w_beat(input row_t row, input int beat);
        noc_bridge_pkg::axi_w_t w;
        w.data = row.wdata + 32'(beat);
        w.strb = (beat % 2 == 1) ? ~row.wstrb : row.wstrb;
        w.last = (beat == int'(row.aw.len));
        return w;
    endfunction

    task automatic fill_table();
        rows[0] = '{kind: KIND_WRITE, aw: make_addr(4'd3, 16'h1000, 8'd3, 3'd2, 2'd1),
                    ar: '0, wdata: 32'ha5a5_0000, wstrb: 4'hf, rdata: '0, resp_count: 2'd2,
                    resp_kinds: {3'd0, `NB_KIND_B_SUBHEADER, `NB_KIND_ROUTING_HEADER}};
        rows[1] = '{kind: KIND_READ, aw: '0, ar: make_addr(4'd6, 16'h2040, 8'd1, 3'd2, 2'd1),
                    wdata: '0, wstrb: '0, rdata: 32'h1234_5670, resp_count: 2'd3,
                    resp_kinds: {`NB_KIND_R_DATA, `NB_KIND_R_DATA, `NB_KIND_ROUTING_HEADER}};
        rows[2] = '{kind: KIND_BOTH, aw: make_addr(4'd11, 16'h3000, 8'd2, 3'd2, 2'd1),
                    ar: make_addr(4'd1, 16'h0ffc, 8'd0, 3'd2, 2'd0), wdata: 32'h0bad_0000,
                    wstrb: 4'h3, rdata: 32'hdead_0000, resp_count: 2'd3,
                    resp_kinds: {`NB_KIND_W_DATA, `NB_KIND_R_DATA, `NB_KIND_B_SUBHEADER}};
        rows[3] = '{kind: KIND_WRITE, aw: make_addr(4'd15, 16'h4444, 8'd0, 3'd1, 2'd0),
                    ar: '0, wdata: 32'h1111_2222, wstrb: 4'h5, rdata: '0, resp_count: 2'd2,
                    resp_kinds: {3'd0, `NB_KIND_B_SUBHEADER, `NB_KIND_ROUTING_HEADER}};
        rows[4] = '{kind: KIND_BOTH, aw: make_addr(4'd8, 16'h5000, 8'd7, 3'd2, 2'd1),
                    ar: make_addr(4'd14, 16'h6000, 8'd3, 3'd2, 2'd1), wdata: 32'h7777_0000,
                    wstrb: 4'hc, rdata: 32'hbeef_0000, resp_count: 2'd3,
                    resp_kinds: {`NB_KIND_B_SUBHEADER, `NB_KIND_R_DATA, `NB_KIND_ROUTING_HEADER}};
        rows[5] = '{kind: KIND_READ, aw: '0, ar: make_addr(4'd2, 16'h7ff0, 8'd0, 3'd0, 2'd1),
                    wdata: '0, wstrb: '0, rdata: 32'hcafe_0001, resp_count: 2'd2,
                    resp_kinds: {3'd0, `NB_KIND_R_DATA, `NB_KIND_ROUTING_HEADER}};
    endtask

    task automatic push_packet(input row_t row, input logic is_read);
        noc_bridge_pkg::axi_addr_t       a;
        noc_bridge_pkg::routing_header_t h;
        noc_bridge_pkg::addr_subheader_t s;
        noc_bridge_pkg::w_flit_t         wf;
        noc_bridge_pkg::axi_w_t          w;
        noc_bridge_pkg::axis_flit_t      f;
        int                              node;
        int                              beat;
        a              = is_read ? row.ar : row.aw;
        node           = int'(a.id) - 1;  // Node 1 sits at (0,0), numbering runs along X first
        h              = '0;
        h.packet_count = is_read ? 8'd1 : a.len + 8'd2;
        h.source_x     = `NB_COORD_X_WIDTH'(ROUTER_X);
        h.source_y     = `NB_COORD_Y_WIDTH'(ROUTER_Y);
        h.dest_x       = `NB_COORD_X_WIDTH'(node % `NB_MESH_X);
        h.dest_y       = `NB_COORD_Y_WIDTH'(node / `NB_MESH_X);
        f              = '0;
        f.tid          = noc_bridge_pkg::ROUTING_HEADER;
        f.tdata        = h;
        f.tstrb        = '1;
        exp_q.push_back(f);
        s       = '0;
        s.id    = a.id;
        s.addr  = a.addr;
        s.len   = a.len;
        s.size  = a.size;
        s.burst = a.burst;
        f.tid   = is_read ? noc_bridge_pkg::AR_SUBHEADER : noc_bridge_pkg::AW_SUBHEADER;
        f.tdata = s;
        f.tlast = is_read;
        exp_q.push_back(f);
        if (!is_read) begin
            for (beat = 0; beat <= int'(a.len); beat++) begin
                w       = w_beat(row, beat);
                wf      = '0;
                wf.data = w.data;
                f.tid   = noc_bridge_pkg::W_DATA;
                f.tdata = wf;
                f.tstrb = w.strb;
                f.tlast = w.last;
                exp_q.push_back(f);
            end
        end
    endtask

    task automatic compare_packets(input int row_idx);
        noc_bridge_pkg::axis_flit_t got;
        noc_bridge_pkg::axis_flit_t exp;
        check_value($sformatf("req_flit_o count in row %0d", row_idx), got_q.size(), exp_q.size());
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            check_value("req_flit_o.tid", got.tid, exp.tid);
            check_value("req_flit_o.tdata", got.tdata, exp.tdata);
            check_value("req_flit_o.tstrb", got.tstrb, exp.tstrb);
            check_value("req_flit_o.tlast", got.tlast, exp.tlast);
        end
        exp_q.delete();
        got_q.delete();
    endtask

    // Channel 0 is AW, 1 is AR, anything else is W
    task automatic wait_handshake(input int channel);
        logic moved;
        moved = 1'b0;
        while (!moved) begin
            #(SAMPLE_DELAY);
            case (channel)
                0: moved = aw_ready_o;
                1: moved = ar_ready_o;
                default: moved = w_ready_o;
            endcase
            @(negedge ACLK);
        end
    endtask

    task automatic send_addr(input logic is_read, input noc_bridge_pkg::axi_addr_t a);
        if (is_read) begin
            ar_i       = a;
            ar_valid_i = 1'b1;
            wait_handshake(1);
            ar_valid_i = 1'b0;
        end
        else begin
            aw_i       = a;
            aw_valid_i = 1'b1;
            wait_handshake(0);
            aw_valid_i = 1'b0;
        end
    endtask

    task automatic send_w(input row_t row);
        int beat;
        for (beat = 0; beat <= int'(row.aw.len); beat++) begin
            w_i       = w_beat(row, beat);
            w_valid_i = 1'b1;
            wait_handshake(2);
        end
        w_valid_i = 1'b0;
    endtask

    task automatic send_resp(input row_t row);
        noc_bridge_pkg::flit_kind_e kind;
        noc_bridge_pkg::b_flit_t    bf;
        noc_bridge_pkg::r_flit_t    rf;
        logic                       moved;
        logic                       last;
        int                         i;
        for (i = 0; i < int'(row.resp_count); i++) begin
            kind              = noc_bridge_pkg::flit_kind_e'(row.resp_kinds[3*i +: 3]);
            last              = (i == int'(row.resp_count) - 1);
            bf                = '0;
            bf.id             = row.aw.id;
            rf                = '0;
            rf.id             = row.ar.id;
            rf.data           = row.rdata + 32'(i);
            resp_flit_i       = '0;
            resp_flit_i.tid   = kind;
            resp_flit_i.tstrb = '1;
            resp_flit_i.tlast = last;
            case (kind)
                noc_bridge_pkg::B_SUBHEADER: resp_flit_i.tdata = bf;
                noc_bridge_pkg::R_DATA: resp_flit_i.tdata = rf;
                default: resp_flit_i.tdata = {8'h5a, row.rdata};
            endcase
            resp_valid_i = 1'b1;
            moved        = 1'b0;
            while (!moved) begin
                #(SAMPLE_DELAY);
                case (kind)
                    noc_bridge_pkg::B_SUBHEADER: begin
                        check_value("b_valid_o", b_valid_o, 1'b1);
                        check_value("b_o.id", b_o.id, row.aw.id);
                        check_value("resp_ready_o", resp_ready_o, b_ready_i);
                    end
                    noc_bridge_pkg::R_DATA: begin
                        check_value("r_valid_o", r_valid_o, 1'b1);
                        check_value("r_o.id", r_o.id, row.ar.id);
                        check_value("r_o.data", r_o.data, rf.data);
                        check_value("r_o.last", r_o.last, last);
                        check_value("resp_ready_o", resp_ready_o, r_ready_i);
                    end
                    default: begin
                        check_value("b_valid_o", b_valid_o, 1'b0);
                        check_value("r_valid_o", r_valid_o, 1'b0);
                        check_value("resp_ready_o", resp_ready_o, 1'b1);
                    end
                endcase
                moved = resp_ready_o;
                @(negedge ACLK);
            end
        end
        resp_valid_i = 1'b0;
    endtask

    initial begin
        req_ready_i = 1'b0;
        b_ready_i   = 1'b0;
        r_ready_i   = 1'b0;
        void'($urandom(32'hd642));
        forever begin
            @(negedge ACLK);
            req_ready_i = ($urandom % 4) != 0;
            b_ready_i   = ($urandom % 3) != 0;
            r_ready_i   = ($urandom % 3) != 0;
        end
    end

    initial begin
        @(posedge ARESETn);
        forever begin
            @(negedge ACLK);
            #(SAMPLE_DELAY);
            if (req_valid_o && req_ready_i) begin
                got_q.push_back(req_flit_o);
            end
            if (!req_ready_i) begin
                check_value("aw_ready_o", aw_ready_o, 1'b0);
                check_value("ar_ready_o", ar_ready_o, 1'b0);
                check_value("w_ready_o", w_ready_o, 1'b0);
            end
            if (!resp_valid_i) begin
                check_value("b_valid_o", b_valid_o, 1'b0);
                check_value("r_valid_o", r_valid_o, 1'b0);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        row_t row;
        int   row_idx;
        errors       = 0;
        checks       = 0;
        next_is_ar   = 1'b0;
        aw_i         = '0;
        aw_valid_i   = 1'b0;
        ar_i         = '0;
        ar_valid_i   = 1'b0;
        w_i          = '0;
        w_valid_i    = 1'b0;
        resp_flit_i  = '0;
        resp_valid_i = 1'b0;
        fill_table();

        @(posedge ARESETn);
        @(negedge ACLK);
        #(SAMPLE_DELAY);
        check_value("aw_ready_o", aw_ready_o, 1'b0);
        check_value("ar_ready_o", ar_ready_o, 1'b0);
        check_value("w_ready_o", w_ready_o, 1'b0);
        check_value("req_valid_o", req_valid_o, 1'b0);

        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
            row = rows[row_idx];
            @(negedge ACLK);
            case (row.kind)
                KIND_WRITE: push_packet(row, 1'b0);
                KIND_READ: push_packet(row, 1'b1);
                default: begin
                    push_packet(row, next_is_ar);
                    push_packet(row, !next_is_ar);
                end
            endcase
            // The kind that finished last hands priority to the other one
            next_is_ar = (row.kind == KIND_WRITE) || (row.kind == KIND_BOTH && next_is_ar);
            fork
                if (row.kind != KIND_READ) begin
                    send_addr(1'b0, row.aw);
                end
                if (row.kind != KIND_READ) begin
                    send_w(row);
                end
                if (row.kind != KIND_WRITE) begin
                    send_addr(1'b1, row.ar);
                end
                send_resp(row);
            join
            compare_packets(row_idx);
        end

        $display("Run complete with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
logic/noc_bridge_pkg.sv
logic/req_arbiter.sv
logic/req_packetizer.sv
logic/resp_depacketizer.sv
logic/noc_initiator_bridge.sv
dv/tb_clock_gen.sv
dv/tb_noc_initiator_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module tb_noc_initiator_bridge

./obj_dir/Vtb_noc_initiator_bridge | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
